//--- verilog/rv32i_isa_pkg.sv
// ##################################################################
// rv32i isa package: opcodes, funct3 codes and datapath select codes
// ##################################################################
`default_nettype none

package rv32i_isa_pkg;

    // major opcodes, only lui/auipc/imm/reg are executed
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011,
        op_b_csr   = 7'b1110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    typedef enum logic [2:0] {
        alu_op_add = 3'b000,
        alu_op_sll = 3'b001,
        alu_op_sra = 3'b010,
        alu_op_sub = 3'b011,
        alu_op_xor = 3'b100,
        alu_op_srl = 3'b101,
        alu_op_or  = 3'b110,
        alu_op_and = 3'b111
    } alu_ops_t;

    // same codes as the branch funct3
    typedef enum logic [2:0] {
        cmp_op_blt  = 3'b100,
        cmp_op_bltu = 3'b110
    } cmp_ops_t;

    typedef enum logic [1:0] {
        rs1_out        = 2'b00,
        pc_out         = 2'b01,
        invalid_alu_m1 = 2'b11
    } alu_m1_sel_t;

    typedef enum logic [1:0] {
        rs2_out        = 2'b00,
        i_imm_m        = 2'b01,
        u_imm_m        = 2'b10,
        invalid_alu_m2 = 2'b11
    } alu_m2_sel_t;

    typedef enum logic [1:0] {
        rs2_out_cmp = 2'b00,
        i_imm_m_cmp = 2'b01,
        invalid_cmp = 2'b11
    } cmp_sel_t;

    typedef enum logic [1:0] {
        alu_out_rd = 2'b00,
        u_imm_m_rd = 2'b01,
        ext_br     = 2'b10,
        invalid_rd = 2'b11
    } rd_m_sel_t;

endpackage

`default_nettype wire

//--- verilog/rv32i_pipe_pkg.sv
// ##################################################################
// rv32i pipeline package: stage control words and stage registers
// ##################################################################
`default_nettype none

package rv32i_pipe_pkg;

    import rv32i_isa_pkg::*;

    // 12 bits
    typedef struct packed {
        alu_ops_t    aluop;
        alu_m1_sel_t alu_m1_sel;
        alu_m2_sel_t alu_m2_sel;
        cmp_sel_t    cmp_sel;
        cmp_ops_t    cmpop;
    } ex_ctrl_t;

    typedef struct packed {
        logic      regf_we;
        rd_m_sel_t rd_m_sel;
    } wb_ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic        valid;
    } if_id_stage_reg_t;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [63:0] order;
        logic        valid;
        ex_ctrl_t    ex_ctrl;
        wb_ctrl_t    wb_ctrl;
        logic [31:0] i_imm;
        logic [31:0] u_imm;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [4:0]  rs1_s;
        logic [4:0]  rs2_s;
        logic [4:0]  rd_s;
    } id_ex_stage_reg_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [63:0] order;
        logic        valid;
        wb_ctrl_t    wb_ctrl;
        logic [4:0]  rd_s;
        logic [31:0] rd_v;
    } ex_wb_stage_reg_t;

endpackage

`default_nettype wire

//--- verilog/regf_rd_if.sv
// ##################################################################
// register file read port between decode and the register file
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

interface regf_rd_if;

    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;

    modport decode (output rs1_s, output rs2_s, input rs1_v, input rs2_v);

    modport regfile (input rs1_s, input rs2_s, output rs1_v, output rs2_v);

endinterface

`default_nettype wire

//--- verilog/fetch.sv
// ##################################################################
// fetch: program counter and instruction memory request
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module fetch #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             imem_resp,
    output logic                             imem_req,
    output logic [31:0]                      imem_addr,
    output rv32i_pipe_pkg::if_id_stage_reg_t if_id_reg
);

    logic [31:0] pc;
    logic [31:0] pc_next;

    assign pc_next = pc + 32'd4;

    // next request goes out right after each response, so the port always asks
    assign imem_req  = 1'b1;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (imem_resp) begin
            pc <= pc_next;
        end
    end

    // record is valid for the one cycle after a response
    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_reg.valid <= 1'b0;
        end else begin
            if_id_reg.valid <= imem_resp;
            if (imem_resp) begin
                if_id_reg.pc      <= pc;
                if_id_reg.pc_next <= pc_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/decode.sv
// ##################################################################
// decode: instruction latch, immediates, control ROM, sequence count
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module decode (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             imem_resp,
    input  logic [31:0]                      imem_rdata,
    regf_rd_if.decode                        rd_port,
    input  rv32i_pipe_pkg::if_id_stage_reg_t if_id_reg,
    output rv32i_pipe_pkg::id_ex_stage_reg_t id_ex_reg
);

    import rv32i_isa_pkg::*;
    import rv32i_pipe_pkg::*;

    logic [31:0] inst;
    logic [63:0] order;
    logic [63:0] seq_cnt;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [31:0] i_imm;
    logic [31:0] u_imm;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    alu_ops_t    f3_aluop;
    ex_ctrl_t    ex_ctrl;
    wb_ctrl_t    wb_ctrl;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign i_imm  = {{21{inst[31]}}, inst[30:20]};
    assign u_imm  = {inst[31:12], 12'h000};

    // instruction word arrives with the response
    always_ff @(posedge clk) begin
        if (imem_resp) begin
            inst <= imem_rdata;
        end
    end

    // order of the latched instruction, first one is 0
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_cnt <= '0;
            order   <= '0;
        end else if (imem_resp) begin
            seq_cnt <= seq_cnt + 64'd1;
            order   <= seq_cnt;
        end
    end

    // alu op shared by op-imm and op, sub patched in below
    always_comb begin
        case (funct3)
            arith_f3_sll: f3_aluop = alu_op_sll;
            arith_f3_xor: f3_aluop = alu_op_xor;
            arith_f3_sr:  f3_aluop = inst[30] ? alu_op_sra : alu_op_srl;
            arith_f3_or:  f3_aluop = alu_op_or;
            arith_f3_and: f3_aluop = alu_op_and;
            default:      f3_aluop = alu_op_add;
        endcase
    end

    // control ROM
    always_comb begin
        ex_ctrl.aluop      = alu_op_add;
        ex_ctrl.alu_m1_sel = invalid_alu_m1;
        ex_ctrl.alu_m2_sel = invalid_alu_m2;
        ex_ctrl.cmp_sel    = invalid_cmp;
        ex_ctrl.cmpop      = (funct3 == arith_f3_sltu) ? cmp_op_bltu : cmp_op_blt;
        wb_ctrl.regf_we    = 1'b0;
        wb_ctrl.rd_m_sel   = invalid_rd;
        rs1_addr           = '0;
        rs2_addr           = '0;
        unique case (opcode)
            op_b_lui: begin
                wb_ctrl.regf_we  = 1'b1;
                wb_ctrl.rd_m_sel = u_imm_m_rd;
            end
            op_b_auipc: begin
                ex_ctrl.alu_m1_sel = pc_out;
                ex_ctrl.alu_m2_sel = u_imm_m;
                wb_ctrl.regf_we    = 1'b1;
                wb_ctrl.rd_m_sel   = alu_out_rd;
            end
            op_b_imm, op_b_reg: begin
                wb_ctrl.regf_we    = 1'b1;
                ex_ctrl.alu_m1_sel = rs1_out;
                rs1_addr           = inst[19:15];
                ex_ctrl.aluop      = f3_aluop;
                if (opcode == op_b_reg) begin
                    ex_ctrl.alu_m2_sel = rs2_out;
                    ex_ctrl.cmp_sel    = rs2_out_cmp;
                    rs2_addr           = inst[24:20];
                    if (funct3 == arith_f3_add && inst[30]) begin
                        ex_ctrl.aluop = alu_op_sub;
                    end
                end else begin
                    ex_ctrl.alu_m2_sel = i_imm_m;
                    ex_ctrl.cmp_sel    = i_imm_m_cmp;
                end
                // slt and sltu take the compare bit
                if (funct3 == arith_f3_slt || funct3 == arith_f3_sltu) begin
                    wb_ctrl.rd_m_sel = ext_br;
                end else begin
                    wb_ctrl.rd_m_sel = alu_out_rd;
                end
            end
            default: begin
            end
        endcase
    end

    assign rd_port.rs1_s = rs1_addr;
    assign rd_port.rs2_s = rs2_addr;

    always_comb begin
        id_ex_reg.inst    = inst;
        id_ex_reg.pc      = if_id_reg.pc;
        id_ex_reg.order   = order;
        id_ex_reg.valid   = if_id_reg.valid;
        id_ex_reg.ex_ctrl = ex_ctrl;
        id_ex_reg.wb_ctrl = wb_ctrl;
        id_ex_reg.i_imm   = i_imm;
        id_ex_reg.u_imm   = u_imm;
        id_ex_reg.rs1_v   = rd_port.rs1_v;
        id_ex_reg.rs2_v   = rd_port.rs2_v;
        id_ex_reg.rs1_s   = rs1_addr;
        id_ex_reg.rs2_s   = rs2_addr;
        id_ex_reg.rd_s    = inst[11:7];
    end

endmodule

`default_nettype wire

//--- verilog/regfile.sv
// ##################################################################
// regfile: 31 general registers, x0 reads zero, write-through reads
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic        rst,
    regf_rd_if.regfile  rd_port,
    input  logic        regf_we,
    input  logic [4:0]  rd_s,
    input  logic [31:0] rd_v
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regf_we && rd_s != 5'd0) begin
            regs[rd_s] <= rd_v;
        end
    end

    // a write to the same index this cycle wins over the stored value
    always_comb begin
        if (rd_port.rs1_s == 5'd0) begin
            rd_port.rs1_v = '0;
        end else if (regf_we && rd_s == rd_port.rs1_s) begin
            rd_port.rs1_v = rd_v;
        end else begin
            rd_port.rs1_v = regs[rd_port.rs1_s];
        end

        if (rd_port.rs2_s == 5'd0) begin
            rd_port.rs2_v = '0;
        end else if (regf_we && rd_s == rd_port.rs2_s) begin
            rd_port.rs2_v = rd_v;
        end else begin
            rd_port.rs2_v = regs[rd_port.rs2_s];
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute.sv
// ##################################################################
// execute: operand forwarding, ALU, comparator and result select
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module execute (
    input  logic                             clk,
    input  logic                             rst,
    input  rv32i_pipe_pkg::id_ex_stage_reg_t id_ex_reg,
    output rv32i_pipe_pkg::ex_wb_stage_reg_t ex_wb_reg
);

    import rv32i_isa_pkg::*;
    import rv32i_pipe_pkg::*;

    id_ex_stage_reg_t idex;
    logic             fwd_ok;
    logic [31:0]      rs1_fwd;
    logic [31:0]      rs2_fwd;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      cmp_b;
    logic [31:0]      alu_out;
    logic             br_en;
    logic [31:0]      rd_v;

    always_ff @(posedge clk) begin
        if (rst) begin
            idex.valid <= 1'b0;
        end else begin
            idex <= id_ex_reg;
        end
    end

    // bypass from the instruction now in writeback
    assign fwd_ok  = ex_wb_reg.valid && ex_wb_reg.wb_ctrl.regf_we && (ex_wb_reg.rd_s != 5'd0);
    assign rs1_fwd = (fwd_ok && ex_wb_reg.rd_s == idex.rs1_s) ? ex_wb_reg.rd_v : idex.rs1_v;
    assign rs2_fwd = (fwd_ok && ex_wb_reg.rd_s == idex.rs2_s) ? ex_wb_reg.rd_v : idex.rs2_v;

    always_comb begin
        case (idex.ex_ctrl.alu_m1_sel)
            rs1_out: a = rs1_fwd;
            pc_out:  a = idex.pc;
            default: a = '0;
        endcase
        case (idex.ex_ctrl.alu_m2_sel)
            rs2_out: b = rs2_fwd;
            i_imm_m: b = idex.i_imm;
            u_imm_m: b = idex.u_imm;
            default: b = '0;
        endcase
        cmp_b = (idex.ex_ctrl.cmp_sel == i_imm_m_cmp) ? idex.i_imm : rs2_fwd;
    end

    // shift amount is the low 5 bits of operand 2
    always_comb begin
        case (idex.ex_ctrl.aluop)
            alu_op_add: alu_out = a + b;
            alu_op_sll: alu_out = a << b[4:0];
            alu_op_sra: alu_out = unsigned'($signed(a) >>> b[4:0]);
            alu_op_sub: alu_out = a - b;
            alu_op_xor: alu_out = a ^ b;
            alu_op_srl: alu_out = a >> b[4:0];
            alu_op_or:  alu_out = a | b;
            default:    alu_out = a & b;
        endcase
    end

    assign br_en = (idex.ex_ctrl.cmpop == cmp_op_bltu) ? (rs1_fwd < cmp_b)
                                                       : ($signed(rs1_fwd) < $signed(cmp_b));

    always_comb begin
        case (idex.wb_ctrl.rd_m_sel)
            alu_out_rd: rd_v = alu_out;
            u_imm_m_rd: rd_v = idex.u_imm;
            ext_br:     rd_v = {31'd0, br_en};
            default:    rd_v = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_wb_reg.valid <= 1'b0;
        end else begin
            ex_wb_reg.valid   <= idex.valid;
            ex_wb_reg.pc      <= idex.pc;
            ex_wb_reg.order   <= idex.order;
            ex_wb_reg.wb_ctrl <= idex.wb_ctrl;
            ex_wb_reg.rd_s    <= idex.rd_s;
            ex_wb_reg.rd_v    <= rd_v;
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback.sv
// ##################################################################
// writeback: register write port and commit outputs
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module writeback (
    input  rv32i_pipe_pkg::ex_wb_stage_reg_t ex_wb_reg,
    output logic                             regf_we,
    output logic [4:0]                       rd_s,
    output logic [31:0]                      rd_v,
    output logic                             commit_valid,
    output logic [63:0]                      commit_order,
    output logic [31:0]                      commit_pc,
    output logic [4:0]                       commit_rd,
    output logic [31:0]                      commit_rd_v,
    output logic                             commit_we
);

    // bubbles never write
    assign regf_we = ex_wb_reg.valid && ex_wb_reg.wb_ctrl.regf_we;
    assign rd_s    = ex_wb_reg.rd_s;
    assign rd_v    = ex_wb_reg.rd_v;

    assign commit_valid = ex_wb_reg.valid;
    assign commit_order = ex_wb_reg.order;
    assign commit_pc    = ex_wb_reg.pc;
    assign commit_rd    = ex_wb_reg.rd_s;
    assign commit_rd_v  = ex_wb_reg.rd_v;
    assign commit_we    = regf_we;

endmodule

`default_nettype wire

//--- verilog/rv32i_core.sv
// ##################################################################
// rv32i core: fetch, decode, regfile, execute and writeback
// ##################################################################
`default_nettype none
`timescale 1ns/1ps

module rv32i_core #(
    parameter logic [31:0] reset_pc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_resp,
    input  logic [31:0] imem_rdata,
    output logic        commit_valid,
    output logic [63:0] commit_order,
    output logic [31:0] commit_pc,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_rd_v,
    output logic        commit_we
);

    import rv32i_pipe_pkg::*;

    if_id_stage_reg_t if_id_reg;
    id_ex_stage_reg_t id_ex_reg;
    ex_wb_stage_reg_t ex_wb_reg;
    logic             regf_we;
    logic [4:0]       rd_s;
    logic [31:0]      rd_v;

    regf_rd_if rd_port ();

    fetch #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk       (clk),
        .rst       (rst),
        .imem_resp (imem_resp),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .if_id_reg (if_id_reg)
    );

    decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .imem_resp  (imem_resp),
        .imem_rdata (imem_rdata),
        .rd_port    (rd_port.decode),
        .if_id_reg  (if_id_reg),
        .id_ex_reg  (id_ex_reg)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rd_port (rd_port.regfile),
        .regf_we (regf_we),
        .rd_s    (rd_s),
        .rd_v    (rd_v)
    );

    execute u_execute (
        .clk       (clk),
        .rst       (rst),
        .id_ex_reg (id_ex_reg),
        .ex_wb_reg (ex_wb_reg)
    );

    writeback u_writeback (
        .ex_wb_reg    (ex_wb_reg),
        .regf_we      (regf_we),
        .rd_s         (rd_s),
        .rd_v         (rd_v),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_rd_v  (commit_rd_v),
        .commit_we    (commit_we)
    );

endmodule

`default_nettype wire

//--- sim/tb_rv32i_core.sv
// ######################################################################
// testbench for the rv32i core: memory model with random latency and
// a commit checker driven by the pattern file
// ######################################################################
`default_nettype none
`timescale 1ns/1ps

module tb_rv32i_core;

    localparam logic [31:0] reset_pc     = 32'h0000_0100;
    localparam int          max_pat      = 64;
    localparam int          wait_timeout = 50;

    logic        clk;
    logic        rst;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_resp;
    logic [31:0] imem_rdata;
    logic        commit_valid;
    logic [63:0] commit_order;
    logic [31:0] commit_pc;
    logic [4:0]  commit_rd;
    logic [31:0] commit_rd_v;
    logic        commit_we;

    // three words per instruction
    logic [31:0] pat_mem [0:3*max_pat-1];
    int          accept_edge [0:max_pat-1];
    int          n_pat;
    int          errors     = 0;
    int          commit_cnt = 0;
    int          edge_cnt   = 0;
    integer      seed;

    rv32i_core #(
        .reset_pc (reset_pc)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .imem_req     (imem_req),
        .imem_addr    (imem_addr),
        .imem_resp    (imem_resp),
        .imem_rdata   (imem_rdata),
        .commit_valid (commit_valid),
        .commit_order (commit_order),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_rd_v  (commit_rd_v),
        .commit_we    (commit_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    // state expected while nothing has been accepted yet
    task automatic verify_idle_outputs();
        assert (commit_valid == 1'b0)
            else report_mismatch("commit_valid", 64'(commit_valid), 64'd0);
        assert (commit_we == 1'b0)
            else report_mismatch("commit_we", 64'(commit_we), 64'd0);
        assert (imem_req == 1'b1)
            else report_mismatch("imem_req", 64'(imem_req), 64'd1);
        assert (imem_addr == reset_pc)
            else report_mismatch("imem_addr", 64'(imem_addr), 64'(reset_pc));
    endtask

    task automatic wait_for_req();
        int waited;
        waited = 0;
        while (imem_req !== 1'b1 && waited < wait_timeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (imem_req === 1'b1) else begin
            errors++;
            $display("imem_req stayed low for %0d cycles at %0t", wait_timeout, $time);
        end
    endtask

    task automatic check_commit();
        int          idx;
        logic [31:0] col_rd;
        logic [31:0] exp_v;
        idx = commit_cnt;
        commit_cnt++;
        assert (idx < n_pat) else begin
            errors++;
            $display("commit at %0t with no instruction left to retire", $time);
        end
        if (idx < n_pat) begin
            col_rd = pat_mem[3*idx+1];
            exp_v  = pat_mem[3*idx+2];
            assert (commit_order == 64'(idx))
                else report_mismatch("commit_order", commit_order, 64'(idx));
            assert (commit_pc == reset_pc + 32'(4 * idx))
                else report_mismatch("commit_pc", 64'(commit_pc), 64'(reset_pc + 32'(4 * idx)));
            assert (commit_we == col_rd[8])
                else report_mismatch("commit_we", 64'(commit_we), 64'(col_rd[8]));
            assert (commit_rd == col_rd[4:0])
                else report_mismatch("commit_rd", 64'(commit_rd), 64'(col_rd[4:0]));
            if (col_rd[8]) begin
                assert (commit_rd_v == exp_v)
                    else report_mismatch("commit_rd_v", 64'(commit_rd_v), 64'(exp_v));
            end
            // commit falls in the cycle after acceptance edge plus 2
            assert (edge_cnt == accept_edge[idx] + 2) else begin
                errors++;
                $display("instruction %0d committed after edge %0d instead of edge %0d at %0t",
                         idx, edge_cnt, accept_edge[idx] + 2, $time);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            check_commit();
        end
    end

    initial begin : main
        int delay;
        int waited;
        seed       = 32'h3a35_7a47;
        rst        = 1'b1;
        imem_resp  = 1'b0;
        imem_rdata = 32'h0;
        $readmemh("sim/rv32i_patterns.txt", pat_mem);
        n_pat = 0;
        while (n_pat < max_pat && pat_mem[3*n_pat] != 32'h0) begin
            n_pat++;
        end
        assert (n_pat > 0) else begin
            errors++;
            $display("no instructions found in the pattern file");
        end
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #2;
            verify_idle_outputs();
        end
        rst = 1'b0;
        @(posedge clk);
        #2;
        verify_idle_outputs();
        for (int k = 0; k < n_pat; k++) begin
            delay     = $unsigned($random(seed)) % 4;
            imem_resp = 1'b0;
            for (int d = 0; d < delay; d++) begin
                @(posedge clk);
                #2;
            end
            wait_for_req();
            assert (imem_addr == reset_pc + 32'(4 * k))
                else report_mismatch("imem_addr", 64'(imem_addr), 64'(reset_pc + 32'(4 * k)));
            imem_resp      = 1'b1;
            imem_rdata     = pat_mem[3*k];
            accept_edge[k] = edge_cnt + 1;
            @(posedge clk);
            #2;
        end
        imem_resp  = 1'b0;
        imem_rdata = 32'h0;
        waited = 0;
        while (commit_cnt < n_pat && waited < wait_timeout) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (commit_cnt == n_pat) else begin
            errors++;
            $display("timeout with %0d of %0d instructions committed", commit_cnt, n_pat);
        end
        $display("errors: %0d, commits checked: %0d of %0d", errors, commit_cnt, n_pat);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/rv32i_patterns.txt
// columns are instruction word, expected rd in hex plus 100 when it is written, rd value
// instruction n sits at reset_pc plus 4n and an all-zero word ends the list
123450B7 101 12345000
00001117 102 00001104
67808193 103 12345678
FFF00213 104 FFFFFFFF
FFE22293 105 00000000
FFF1B313 106 00000001
FFF1C393 107 EDCBA987
4043D413 108 FEDCBA98
0083D493 109 00EDCBA9
00419513 10A 23456780
00F56593 10B 2345678F
0F05F613 10C 00000080
40B606B3 10D DCBA98F1
4066D733 10E EE5D4C78
00D727B3 10F 00000000
0046B833 110 00000001
00308033 100 2468A678
01006933 112 00000001
0121C9B3 113 12345679
00002183 003 00000000
01218A33 114 12345679

//--- verilog.f
verilog/rv32i_isa_pkg.sv
verilog/rv32i_pipe_pkg.sv
verilog/regf_rd_if.sv
verilog/fetch.sv
verilog/decode.sv
verilog/regfile.sv
verilog/execute.sv
verilog/writeback.sv
verilog/rv32i_core.sv
sim/tb_rv32i_core.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the rv32i core testbench with Verilator
verilator --binary --timing --assert -f verilog.f --top-module tb_rv32i_core -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
